// ==== src.f ====
+incdir+hdl
hdl/corr_sample_pkg.sv
hdl/corr_acc_pkg.sv
hdl/corr_sample_if.sv
hdl/sample_delay_line.sv
hdl/integration_ctrl.sv
hdl/baseline_correlator.sv
hdl/corr_readout.sv
hdl/correlator_top.sv
verif/correlator_tb.sv

// ==== Makefile ====
SRCS := $(filter %.sv,$(shell cat src.f))

obj_dir/Vcorrelator_tb: src.f $(SRCS) hdl/corr_consts.svh
	verilator --binary --assert --timescale 1ns/1ps --top-module correlator_tb -f src.f

run: obj_dir/Vcorrelator_tb
	./obj_dir/Vcorrelator_tb | tee sim.log
	grep -q '^TEST OK$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== verif/correlator_tb.sv ====
// Model sample history persists across starts; strobes go three cycles apart
`timescale 1ns/1ps
`include "corr_consts.svh"

module correlator_tb
	import corr_sample_pkg::*;
	import corr_acc_pkg::*;
();

	localparam int NUM_ROWS        = 5;
	localparam int MAX_COUNT       = (1 << `RESOLUTION) - 1;
	localparam int MID_TAP         = `LAG_CROSS - 1;
	localparam int IMPULSE_AT      = 0;
	localparam int DONE_WAIT_LIMIT = 8;

	typedef enum int {
		PAT_NONE,
		PAT_RANDOM,
		PAT_ONES,
		PAT_ZEROS,
		PAT_IMPULSE
	} pattern_t;

	// Lead strobes go out before start and fill the delay lines
	typedef struct packed {
		int       lead;
		int       len;
		pattern_t kind;
		int       extra;
	} row_t;

	logic                   clk;
	logic                   reset;
	logic                   sample_strobe;
	logic [`NUM_INPUTS-1:0] samples;
	logic                   start;
	int_len_t               integration_len;
	logic                   done;
	baseline_idx_t          rd_baseline;
	lag_idx_t               rd_lag;
	count_t                 rd_real;
	count_t                 rd_imag;

	row_t table_rows [NUM_ROWS];
	int   seed;
	int   cycle_count = 0;
	int   cycle_limit;
	int   error_count;
	int   tests_run;
	int   tests_failed;

	// Reference model
	logic hist [`NUM_INPUTS][`NUM_LAGS];
	int   exp_real [`NUM_BASELINES][`NUM_LAGS];
	int   exp_imag [`NUM_BASELINES][`NUM_LAGS];
	int   pair_a [`NUM_BASELINES];
	int   pair_b [`NUM_BASELINES];

	correlator_top UUT (
		.clk             (clk),
		.reset           (reset),
		.sample_strobe   (sample_strobe),
		.samples         (samples),
		.start           (start),
		.integration_len (integration_len),
		.done            (done),
		.rd_baseline     (rd_baseline),
		.rd_lag          (rd_lag),
		.rd_real         (rd_real),
		.rd_imag         (rd_imag)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic idle(input int n);
		repeat (n) next_cycle();
	endtask

	task automatic report_error(input string msg);
		$display("Error: %s", msg);
		error_count++;
	endtask

	task automatic check_value(input string name, input int bl, input int l,
			input int got, input int expected);
		assert (got == expected) else begin
			$display("Fail %s baseline 0x%0h lag 0x%0h: got 0x%0h, expected 0x%0h",
				name, bl, l, got, expected);
			error_count++;
		end
	endtask

	function automatic string kind_name(input pattern_t kind);
		case (kind)
			PAT_RANDOM:  return "random";
			PAT_ONES:    return "all ones";
			PAT_ZEROS:   return "all zeros";
			PAT_IMPULSE: return "impulse";
			default:     return "none";
		endcase
	endfunction

	function automatic logic [`NUM_INPUTS-1:0] pattern_sample(input pattern_t kind,
			input int idx);
		int                     rnd;
		logic [`NUM_INPUTS-1:0] value;
		value = '0;
		case (kind)
			PAT_RANDOM: begin
				rnd   = $random(seed);
				value = rnd[`NUM_INPUTS-1:0];
			end
			PAT_ONES: value = '1;
			// Input 0 fires once while the others stay high
			PAT_IMPULSE: begin
				value    = '1;
				value[0] = (idx == IMPULSE_AT);
			end
			default: value = '0;
		endcase
		return value;
	endfunction

	task automatic model_clear();
		for (int bl = 0; bl < `NUM_BASELINES; bl++) begin
			for (int l = 0; l < `NUM_LAGS; l++) begin
				exp_real[bl][l] = 0;
				exp_imag[bl][l] = 0;
			end
		end
	endtask

	// Shift the history, then count the tick if it falls inside the integration
	task automatic model_strobe(input logic [`NUM_INPUTS-1:0] value, input bit counted);
		logic sa;
		logic sb;
		for (int n = 0; n < `NUM_INPUTS; n++) begin
			for (int j = `NUM_LAGS - 1; j > 0; j--) begin
				hist[n][j] = hist[n][j-1];
			end
			hist[n][0] = value[n];
		end
		if (counted) begin
			for (int bl = 0; bl < `NUM_BASELINES; bl++) begin
				for (int l = 0; l < `NUM_LAGS; l++) begin
					// Lag k = l - MID_TAP uses tap MID_TAP - k of input b
					sa = hist[pair_a[bl]][MID_TAP];
					sb = hist[pair_b[bl]][2 * MID_TAP - l];
					if (sa && sb && exp_real[bl][l] < MAX_COUNT) begin
						exp_real[bl][l]++;
					end
					if (!sa && !sb && exp_imag[bl][l] < MAX_COUNT) begin
						exp_imag[bl][l]++;
					end
				end
			end
		end
	endtask

	task automatic drive_strobe(input logic [`NUM_INPUTS-1:0] value, input bit counted);
		samples       = value;
		sample_strobe = 1'b1;
		model_strobe(value, counted);
		next_cycle();
		sample_strobe = 1'b0;
	endtask

	task automatic check_all_counts(input pattern_t kind);
		for (int bl = 0; bl < `NUM_BASELINES; bl++) begin
			for (int l = 0; l < `NUM_LAGS; l++) begin
				rd_baseline = baseline_idx_t'(bl);
				rd_lag      = lag_idx_t'(l);
				next_cycle();
				check_value("rd_real", bl, l, int'(rd_real), exp_real[bl][l]);
				check_value("rd_imag", bl, l, int'(rd_imag), exp_imag[bl][l]);
				// Constant inputs must saturate one side and leave the other at zero
				if (kind == PAT_ONES) begin
					check_value("rd_real", bl, l, int'(rd_real), MAX_COUNT);
					check_value("rd_imag", bl, l, int'(rd_imag), 0);
				end else if (kind == PAT_ZEROS) begin
					check_value("rd_real", bl, l, int'(rd_real), 0);
					check_value("rd_imag", bl, l, int'(rd_imag), MAX_COUNT);
				end
			end
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (error_count != errors_before) begin
			tests_failed++;
			$display("Test %0d (%s): failed with %0d errors", tests_run, name,
				error_count - errors_before);
		end else begin
			$display("Test %0d (%s): passed", tests_run, name);
		end
	endtask

	task automatic run_row(input int r);
		row_t row;
		int   waited;
		int   errors_before;
		row           = table_rows[r];
		errors_before = error_count;
		integration_len = int_len_t'(row.len);
		for (int idx = -row.lead; idx < 0; idx++) begin
			drive_strobe(pattern_sample(row.kind, idx), 1'b0);
			idle(2);
		end
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		model_clear();
		for (int idx = 0; idx < row.len; idx++) begin
			assert (done == 1'b0) else report_error($sformatf(
				"done was high before tick %0d of %0d", idx + 1, row.len));
			drive_strobe(pattern_sample(row.kind, idx), 1'b1);
			if (idx < row.len - 1) begin
				idle(2);
			end
		end
		// Done follows the last tick cycle by one
		waited = 0;
		while (done !== 1'b1 && waited < DONE_WAIT_LIMIT) begin
			next_cycle();
			waited++;
		end
		assert (done === 1'b1) else report_error($sformatf(
			"done did not rise within %0d cycles of the last tick", DONE_WAIT_LIMIT));
		if (done === 1'b1) begin
			assert (waited == 1) else report_error($sformatf(
				"done rose %0d cycles after the last tick cycle instead of 1", waited));
		end
		idle(1);
		for (int e = 0; e < row.extra; e++) begin
			drive_strobe(pattern_sample(row.kind, row.len + e), 1'b0);
			idle(2);
		end
		assert (done == 1'b1) else report_error("done fell during strobes after the integration");
		check_all_counts(row.kind);
		finish_test($sformatf("%s, %0d ticks", kind_name(row.kind), row.len), errors_before);
	endtask

	initial begin
		int bl;
		int errors_before;
		clk             = 1'b0;
		reset           = 1'b0;
		sample_strobe   = 1'b0;
		samples         = '0;
		start           = 1'b0;
		integration_len = '0;
		rd_baseline     = '0;
		rd_lag          = '0;
		seed            = 93;
		error_count     = 0;
		tests_run       = 0;
		tests_failed    = 0;

		//                   lead  len  kind         extra
		table_rows[0] = '{0,    40,  PAT_RANDOM,  3};
		table_rows[1] = '{5,    300, PAT_ONES,    2};
		table_rows[2] = '{5,    280, PAT_ZEROS,   2};
		table_rows[3] = '{0,    12,  PAT_IMPULSE, 0};
		table_rows[4] = '{0,    10,  PAT_RANDOM,  1};

		cycle_limit = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			cycle_limit += (table_rows[r].lead + table_rows[r].len
				+ table_rows[r].extra) * 3 + 200;
		end

		bl = 0;
		for (int a = 0; a < `NUM_INPUTS - 1; a++) begin
			for (int b = a + 1; b < `NUM_INPUTS; b++) begin
				pair_a[bl] = a;
				pair_b[bl] = b;
				bl++;
			end
		end
		for (int n = 0; n < `NUM_INPUTS; n++) begin
			for (int j = 0; j < `NUM_LAGS; j++) begin
				hist[n][j] = 1'b0;
			end
		end
		model_clear();

		repeat (5) @(posedge clk);
		#1;
		reset = 1'b1;
		next_cycle();

		errors_before = error_count;
		assert (done == 1'b0) else report_error("done was high after reset");
		check_all_counts(PAT_NONE);
		finish_test("after reset", errors_before);

		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end

		$display("Tests run: %0d, tests failed: %0d, check errors: %0d",
			tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== hdl/correlator_top.sv ====
// Four-input one-bit correlator; strobes at least two cycles apart, no back-pressure
`timescale 1ns/1ps
`include "corr_consts.svh"

module correlator_top
	import corr_sample_pkg::*;
	import corr_acc_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   sample_strobe,
	input  logic [`NUM_INPUTS-1:0] samples,
	input  logic                   start,
	input  int_len_t               integration_len,
	output logic                   done,
	input  baseline_idx_t          rd_baseline,
	input  lag_idx_t               rd_lag,
	output count_t                 rd_real,
	output count_t                 rd_imag
);

	count_t real_all [`NUM_BASELINES][`NUM_LAGS];
	count_t imag_all [`NUM_BASELINES][`NUM_LAGS];

	corr_sample_if smp_bus ();

	sample_delay_line u_delay (
		.clk           (clk),
		.reset         (reset),
		.sample_strobe (sample_strobe),
		.samples       (samples),
		.dl            (smp_bus.delay_src)
	);

	integration_ctrl u_ctrl (
		.clk             (clk),
		.reset           (reset),
		.start           (start),
		.integration_len (integration_len),
		.done            (done),
		.ctl             (smp_bus.ctrl_src)
	);

	// Baselines numbered row by row over pairs a<b
	for (genvar a = 0; a < `NUM_INPUTS - 1; a++) begin : g_in_a
		for (genvar b = a + 1; b < `NUM_INPUTS; b++) begin : g_in_b
			localparam int BL = a * (2 * `NUM_INPUTS - a - 1) / 2 + (b - a - 1);

			baseline_correlator #(
				.IDX_A (input_idx_t'(a)),
				.IDX_B (input_idx_t'(b))
			) u_baseline (
				.clk      (clk),
				.reset    (reset),
				.smp      (smp_bus.corr_sink),
				.real_cnt (real_all[BL]),
				.imag_cnt (imag_all[BL])
			);
		end
	end

	corr_readout u_readout (
		.clk         (clk),
		.reset       (reset),
		.real_all    (real_all),
		.imag_all    (imag_all),
		.rd_baseline (rd_baseline),
		.rd_lag      (rd_lag),
		.rd_real     (rd_real),
		.rd_imag     (rd_imag)
	);

endmodule

// ==== hdl/corr_readout.sv ====
// One cycle read latency; out of range baseline or lag reads back as zero
`timescale 1ns/1ps
`include "corr_consts.svh"

module corr_readout
	import corr_sample_pkg::*;
	import corr_acc_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  count_t        real_all [`NUM_BASELINES][`NUM_LAGS],
	input  count_t        imag_all [`NUM_BASELINES][`NUM_LAGS],
	input  baseline_idx_t rd_baseline,
	input  lag_idx_t      rd_lag,
	output count_t        rd_real,
	output count_t        rd_imag
);

	logic in_range;

	assign in_range = (rd_baseline < `NUM_BASELINES) && (rd_lag < `NUM_LAGS);

	always_ff @(posedge clk) begin
		if (!reset) begin
			rd_real <= '0;
			rd_imag <= '0;
		end else if (in_range) begin
			rd_real <= real_all[rd_baseline][rd_lag];
			rd_imag <= imag_all[rd_baseline][rd_lag];
		end else begin
			rd_real <= '0;
			rd_imag <= '0;
		end
	end

endmodule

// ==== hdl/baseline_correlator.sv ====
// One baseline (IDX_A, IDX_B); counters hold at all ones and only move on tick while run
`timescale 1ns/1ps
`include "corr_consts.svh"

module baseline_correlator
	import corr_sample_pkg::*;
	import corr_acc_pkg::*;
#(
	parameter input_idx_t IDX_A = 0,
	parameter input_idx_t IDX_B = 1
) (
	input  logic  clk,
	input  logic  reset,
	corr_sample_if.corr_sink smp,
	output count_t real_cnt [`NUM_LAGS],
	output count_t imag_cnt [`NUM_LAGS]
);

	localparam count_t MAX_COUNT = '1;

	// Input A always uses the middle tap
	localparam int MID_TAP = `LAG_CROSS - 1;

	for (genvar i = 0; i < `NUM_LAGS; i++) begin : g_lag
		sample_t smp_a;
		sample_t smp_b;
		logic    hit_real;
		logic    hit_imag;

		// Lag k = i-MID_TAP pairs B's tap MID_TAP-k
		assign smp_a = smp.taps[IDX_A][MID_TAP];
		assign smp_b = smp.taps[IDX_B][`NUM_LAGS-1-i];

		// Ones coincide on real, zeros on imaginary
		assign hit_real = smp_a & smp_b;
		assign hit_imag = ~smp_a & ~smp_b;

		always_ff @(posedge clk) begin
			if (!reset || smp.clear) begin
				real_cnt[i] <= '0;
				imag_cnt[i] <= '0;
			end else if (smp.tick && smp.run) begin
				if (hit_real && real_cnt[i] != MAX_COUNT) begin
					real_cnt[i] <= real_cnt[i] + 1'b1;
				end
				if (hit_imag && imag_cnt[i] != MAX_COUNT) begin
					imag_cnt[i] <= imag_cnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

// ==== hdl/integration_ctrl.sv ====
// Start in any state restarts the integration; a length of zero finishes right after the clear
`timescale 1ns/1ps

module integration_ctrl
	import corr_acc_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     start,
	input  int_len_t integration_len,
	output logic     done,
	corr_sample_if.ctrl_src ctl
);

	integ_state_t state;
	int_len_t     tick_cnt;
	int_len_t     next_cnt;

	assign next_cnt = tick_cnt + 16'd1;

	always_ff @(posedge clk) begin
		if (!reset) begin
			state    <= INTEG_IDLE;
			tick_cnt <= '0;
			ctl.clear <= 1'b0;
		end else begin
			// Clear pulse trails the start by one cycle
			ctl.clear <= start;
			if (start) begin
				state    <= INTEG_RUN;
				tick_cnt <= '0;
			end else begin
				case (state)
					INTEG_RUN: begin
						if (ctl.clear) begin
							// Tick under clear is not counted
							if (integration_len == '0) begin
								state <= INTEG_HOLD;
							end
						end else if (ctl.tick) begin
							tick_cnt <= next_cnt;
							if (next_cnt == integration_len) begin
								state <= INTEG_HOLD;
							end
						end
					end
					INTEG_HOLD: begin
						state <= INTEG_HOLD;
					end
					default: begin
						state <= INTEG_IDLE;
					end
				endcase
			end
		end
	end

	assign ctl.run = (state == INTEG_RUN);
	assign done    = (state == INTEG_HOLD);

endmodule

// ==== hdl/sample_delay_line.sv ====
// Strobes must be at least two cycles apart; tick follows each strobe by one cycle
`timescale 1ns/1ps
`include "corr_consts.svh"

module sample_delay_line
	import corr_sample_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   sample_strobe,
	input  logic [`NUM_INPUTS-1:0] samples,
	corr_sample_if.delay_src       dl
);

	// Taps and tick update on the same edge so they line up
	always_ff @(posedge clk) begin
		if (!reset) begin
			dl.tick <= 1'b0;
			for (int i = 0; i < `NUM_INPUTS; i++) begin
				dl.taps[i] <= '0;
			end
		end else begin
			dl.tick <= sample_strobe;
			if (sample_strobe) begin
				for (int i = 0; i < `NUM_INPUTS; i++) begin
					// Newest sample enters at tap 0
					dl.taps[i] <= {dl.taps[i][`NUM_LAGS-2:0], sample_t'(samples[i])};
				end
			end
		end
	end

endmodule

// ==== hdl/corr_sample_if.sv ====
// Delay line taps and integration controls; tick and clear are single-cycle pulses
`timescale 1ns/1ps
`include "corr_consts.svh"

interface corr_sample_if
	import corr_sample_pkg::*;
();

	tap_vec_t taps [`NUM_INPUTS];
	logic tick;
	logic clear;
	logic run;

	modport delay_src (
		output taps,
		output tick
	);

	modport ctrl_src (
		input  tick,
		output clear,
		output run
	);

	modport corr_sink (
		input taps,
		input tick,
		input clear,
		input run
	);

endinterface

// ==== hdl/corr_acc_pkg.sv ====
// Accumulation types; baseline_idx_t is 3 bits, so at most 8 baselines are addressable
`include "corr_consts.svh"

package corr_acc_pkg;

	// Saturating count, max value 2^RESOLUTION-1
	typedef logic [`RESOLUTION-1:0] count_t;

	// Pairs (a,b) with a<b numbered in order
	// (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
	typedef logic [2:0] baseline_idx_t;

	// Integration length in sample ticks
	typedef logic [15:0] int_len_t;

	// Integration controller states
	typedef enum logic [1:0] {
		INTEG_IDLE,
		INTEG_RUN,
		INTEG_HOLD
	} integ_state_t;

endpackage

// ==== hdl/corr_sample_pkg.sv ====
// Sample side types; lag_idx_t is fixed at 3 bits, enough for up to 8 lags
`include "corr_consts.svh"

package corr_sample_pkg;

	// One-bit sample as seen on each input
	typedef logic sample_t;

	// Tap j holds the sample taken j strobes ago
	typedef logic [`NUM_LAGS-1:0] tap_vec_t;

	// Selects one of the sampled inputs
	typedef logic [$clog2(`NUM_INPUTS)-1:0] input_idx_t;

	// Index i stands for lag i-(LAG_CROSS-1)
	typedef logic [2:0] lag_idx_t;

endpackage

// ==== hdl/corr_consts.svh ====
// Correlator sizing; LAG_CROSS above 4 needs wider lag indices in corr_sample_pkg
`ifndef CORR_CONSTS_SVH
`define CORR_CONSTS_SVH

// Sampled one-bit inputs
`define NUM_INPUTS 4

// Lags run from -(LAG_CROSS-1) to +(LAG_CROSS-1)
`define LAG_CROSS 3
`define NUM_LAGS (2 * `LAG_CROSS - 1)

// One baseline per unordered input pair
`define NUM_BASELINES (`NUM_INPUTS * (`NUM_INPUTS - 1) / 2)

// Counter width, saturates at all ones
`define RESOLUTION 8

`endif
